/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_mcu_pwr
FILELIST = all.f
LOG      = sim.log

.PHONY: all run lint clean

all: run

run:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

/* all.f */
rtl/mcu_pwr_pkg.sv
rtl/pwr_domain_seq.sv
rtl/pwr_target_ctrl.sv
rtl/irq_vector_collect.sv
rtl/domain_rst_ctrl.sv
rtl/mcu_pwr_top.sv
test/tb_mcu_pwr.sv

/* rtl/domain_rst_ctrl.sv */
// Per-domain resets: synchronized system reset AND debug ndmreset AND sequencer reset.
// Release is two clocks after arst_n_i goes high; assertion is immediate.
`timescale 1ns/1ns
`default_nettype none

module domain_rst_ctrl
  import mcu_pwr_pkg::*;
(
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     debug_ndmreset_ni,
  input  dom_vec_t seq_rst_ni,
  output dom_vec_t dom_rst_no
);

  logic [1:0] sync_q;
  logic       sys_rst_n;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  assign sys_rst_n  = sync_q[1];
  assign dom_rst_no = {NUM_DOMAINS{sys_rst_n & debug_ndmreset_ni}} & seq_rst_ni;

endmodule

`default_nettype wire

/* rtl/irq_vector_collect.sv */
// Registered 32-bit interrupt vector, one cycle behind the sources.
// Spare source bits are not mapped.
`timescale 1ns/1ns
`default_nettype none

module irq_vector_collect
  import mcu_pwr_pkg::*;
(
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  irq_src_t irq_src_i,
  output irq_vec_t intr_o,
  output logic     wake_o
);

  logic [14:0] fast_intr;
  irq_vec_t    intr_d;
  irq_vec_t    intr_q;

  // fast group, timer 1 in the lowest bit
  assign fast_intr = {
    1'b0,
    irq_src_i.gpio_ao,
    irq_src_i.spi_flash,
    irq_src_i.spi,
    irq_src_i.dma_done,
    irq_src_i.timer[3],
    irq_src_i.timer[2],
    irq_src_i.timer[1]
  };

  // standard machine irq slots: msi 3, mti 7, mei 11
  assign intr_d = {
    1'b0, fast_intr, 4'b0, irq_src_i.external, 3'b0, irq_src_i.timer[0], 3'b0,
    irq_src_i.software, 3'b0
  };

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      intr_q <= '0;
    end else begin
      intr_q <= intr_d;
    end
  end

  assign intr_o = intr_q;
  assign wake_o = |intr_q;

endmodule

`default_nettype wire

/* rtl/mcu_pwr_pkg.sv */
// Shared types for the always-on power and reset control.
// Five fixed domains. Only the two memory banks support retention.
`default_nettype none

package mcu_pwr_pkg;

  typedef logic [2:0] dom_idx_t;

  localparam dom_idx_t DOM_CPU    = 3'd0;
  localparam dom_idx_t DOM_PERIPH = 3'd1;
  localparam dom_idx_t DOM_MEM0   = 3'd2;
  localparam dom_idx_t DOM_MEM1   = 3'd3;
  localparam dom_idx_t DOM_EXT0   = 3'd4;

  localparam int NUM_DOMAINS = 5;

  // one flag per domain, bit index is the domain index
  typedef logic [NUM_DOMAINS-1:0] dom_vec_t;

  // domains with retentive memories
  localparam dom_vec_t RET_DOMAINS = dom_vec_t'((1 << DOM_MEM0) | (1 << DOM_MEM1));

  typedef enum logic [1:0] {
    PWR_OFF   = 2'd0,
    PWR_ON    = 2'd1,
    PWR_RET   = 2'd2,
    PWR_UNRET = 2'd3
  } pwr_op_e;

  typedef struct packed {
    logic     valid;
    dom_idx_t domain;
    pwr_op_e  op;
  } pwr_cmd_t;

  // all controls active low
  typedef struct packed {
    logic pwrgate_en_n;
    logic isogate_en_n;
    logic rst_n;
    logic clkgate_en_n;
    logic retentive_en_n;
  } pwr_ctrl_t;

  typedef struct packed {
    logic [3:0] timer;
    logic       software;
    logic       external;
    logic       dma_done;
    logic       spi;
    logic       spi_flash;
    logic [7:0] gpio_ao;
    logic [3:0] spare;
  } irq_src_t;

  typedef logic [31:0] irq_vec_t;

  typedef enum logic [3:0] {
    SEQ_ON,
    SEQ_CLK_GATE,
    SEQ_ISO_ON,
    SEQ_RST_ON,
    SEQ_SW_OFF,
    SEQ_OFF,
    SEQ_SW_ON,
    SEQ_ISO_REL,
    SEQ_RST_REL
  } seq_state_e;

endpackage

`default_nettype wire

/* rtl/mcu_pwr_top.sv */
// Always-on power and reset control for the five MCU domains.
// Spare interrupt sources are tied off here.
`timescale 1ns/1ns
`default_nettype none

module mcu_pwr_top
  import mcu_pwr_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  pwr_cmd_t                    pwr_cmd_i,
  input  logic                        core_sleep_i,
  input  logic                        debug_ndmreset_ni,
  input  irq_src_t                    irq_src_i,
  input  dom_vec_t                    switch_ack_ni,
  output pwr_ctrl_t [NUM_DOMAINS-1:0] dom_ctrl_o,
  output dom_vec_t                    dom_rst_no,
  output dom_vec_t                    dom_on_o,
  output dom_vec_t                    dom_busy_o,
  output irq_vec_t                    intr_o
);

  irq_src_t irq_src;
  logic     wake;
  dom_vec_t target_on;
  dom_vec_t target_ret;
  dom_vec_t seq_rst_n;

  always_comb begin
    irq_src       = irq_src_i;
    irq_src.spare = '0;
  end

  irq_vector_collect irq_vector_collect_i (
    .clk_i,
    .arst_n_i,
    .irq_src_i (irq_src),
    .intr_o,
    .wake_o    (wake)
  );

  pwr_target_ctrl pwr_target_ctrl_i (
    .clk_i,
    .arst_n_i,
    .pwr_cmd_i,
    .core_sleep_i,
    .wake_i       (wake),
    .target_on_o  (target_on),
    .target_ret_o (target_ret)
  );

  // one sequencer per domain, retention on the memory banks only
  for (genvar i = 0; i < NUM_DOMAINS; i++) begin : gen_dom
    pwr_domain_seq #(
      .HAS_RET (RET_DOMAINS[i])
    ) pwr_domain_seq_i (
      .clk_i,
      .arst_n_i,
      .target_on_i   (target_on[i]),
      .target_ret_i  (target_ret[i]),
      .switch_ack_ni (switch_ack_ni[i]),
      .ctrl_o        (dom_ctrl_o[i]),
      .busy_o        (dom_busy_o[i]),
      .on_o          (dom_on_o[i])
    );

    assign seq_rst_n[i] = dom_ctrl_o[i].rst_n;
  end

  domain_rst_ctrl domain_rst_ctrl_i (
    .clk_i,
    .arst_n_i,
    .debug_ndmreset_ni,
    .seq_rst_ni (seq_rst_n),
    .dom_rst_no
  );

endmodule

`default_nettype wire

/* rtl/pwr_domain_seq.sv */
// Power sequencer for one domain. Switch ack is active low: low = switch on, high = off.
// Targets that change mid-sequence take effect once the sequence is done.
`timescale 1ns/1ns
`default_nettype none

module pwr_domain_seq
  import mcu_pwr_pkg::*;
#(
  parameter bit HAS_RET = 1'b0
) (
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  logic      target_on_i,
  input  logic      target_ret_i,
  input  logic      switch_ack_ni,
  output pwr_ctrl_t ctrl_o,
  output logic      busy_o,
  output logic      on_o
);

  seq_state_e state_q;
  seq_state_e state_d;
  logic       ret_n_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      SEQ_ON: begin
        if (!target_on_i) begin
          state_d = SEQ_CLK_GATE;
        end
      end
      SEQ_CLK_GATE: state_d = SEQ_ISO_ON;
      SEQ_ISO_ON:   state_d = SEQ_RST_ON;
      SEQ_RST_ON:   state_d = SEQ_SW_OFF;
      // wait for the switch to report open
      SEQ_SW_OFF: begin
        if (switch_ack_ni) begin
          state_d = SEQ_OFF;
        end
      end
      SEQ_OFF: begin
        if (target_on_i) begin
          state_d = SEQ_SW_ON;
        end
      end
      // wait for the switch to report closed
      SEQ_SW_ON: begin
        if (!switch_ack_ni) begin
          state_d = SEQ_ISO_REL;
        end
      end
      SEQ_ISO_REL: state_d = SEQ_RST_REL;
      SEQ_RST_REL: state_d = SEQ_ON;
      default:     state_d = SEQ_ON;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= SEQ_ON;
      ret_n_q <= 1'b1;
    end else begin
      state_q <= state_d;
      // retention only while staying on
      ret_n_q <= !(HAS_RET && target_ret_i && state_q == SEQ_ON && state_d == SEQ_ON);
    end
  end

  // controls decoded from the step of the sequence
  always_comb begin
    ctrl_o.pwrgate_en_n   = !(state_q inside {SEQ_SW_OFF, SEQ_OFF});
    ctrl_o.isogate_en_n   = !(state_q inside {SEQ_ISO_ON, SEQ_RST_ON, SEQ_SW_OFF, SEQ_OFF,
                                              SEQ_SW_ON});
    ctrl_o.rst_n          = !(state_q inside {SEQ_RST_ON, SEQ_SW_OFF, SEQ_OFF, SEQ_SW_ON,
                                              SEQ_ISO_REL});
    ctrl_o.clkgate_en_n   = (state_q == SEQ_ON);
    ctrl_o.retentive_en_n = ret_n_q;
  end

  assign busy_o = !(state_q inside {SEQ_ON, SEQ_OFF});
  assign on_o   = (state_q == SEQ_ON);

endmodule

`default_nettype wire

/* rtl/pwr_target_ctrl.sv */
// Requested power and retention state per domain.
// Commands to unknown domains are dropped; retention only sticks on retentive domains.
`timescale 1ns/1ns
`default_nettype none

module pwr_target_ctrl
  import mcu_pwr_pkg::*;
(
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  pwr_cmd_t pwr_cmd_i,
  input  logic     core_sleep_i,
  input  logic     wake_i,
  output dom_vec_t target_on_o,
  output dom_vec_t target_ret_o
);

  dom_vec_t req_on_q;
  dom_vec_t req_ret_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      req_on_q  <= '1;
      req_ret_q <= '0;
    end else begin
      for (int d = 0; d < NUM_DOMAINS; d++) begin
        if (pwr_cmd_i.valid && pwr_cmd_i.domain == dom_idx_t'(d)) begin
          case (pwr_cmd_i.op)
            PWR_OFF:   req_on_q[d] <= 1'b0;
            PWR_ON:    req_on_q[d] <= 1'b1;
            PWR_RET:   req_ret_q[d] <= RET_DOMAINS[d];
            PWR_UNRET: req_ret_q[d] <= 1'b0;
          endcase
        end
      end
      // pending interrupt cancels a cpu off request
      if (wake_i) begin
        req_on_q[DOM_CPU] <= 1'b1;
      end
    end
  end

  // cpu may only go down while the core sleeps
  always_comb begin
    target_on_o          = req_on_q;
    target_on_o[DOM_CPU] = req_on_q[DOM_CPU] | ~core_sleep_i;
  end

  assign target_ret_o = req_ret_q;

endmodule

`default_nettype wire

/* test/pwr_stim.mem */
// cmd {valid,domain,op}  sleep  irq_src  debug_ndmreset_n  exp_on  exp_ret  exp_intr
// all hex; exp_ret bit set = retention active
00 0 000000 1 1f 00 00000000 // idle
24 0 000000 1 1d 00 00000000 // periph off
30 0 000000 1 0d 00 00000000 // ext0 off
25 0 000000 1 0f 00 00000000 // periph on
31 0 000000 1 1f 00 00000000 // ext0 on
2a 0 000000 1 1f 04 00000000 // mem0 retention
26 0 000000 1 1f 04 00000000 // periph retention, no effect
2e 0 000000 1 1f 0c 00000000 // mem1 retention
2b 0 000000 1 1f 08 00000000 // mem0 retention off
3c 0 000000 1 1f 08 00000000 // domain 7, dropped
20 0 000000 1 1f 08 00000000 // cpu off while awake
00 1 000000 1 1e 08 00000000 // core sleeps, cpu goes off
00 1 008000 1 1f 08 00000800 // external irq wakes cpu
00 0 000000 1 1f 08 00000000
00 0 030000 1 1f 08 00000088 // timer0 and software
00 0 008a5f 1 1f 08 29400800 // external, gpio_ao, spare
00 0 1c7000 1 1f 08 003f0000 // timer3..1, dma, spi, spi flash
00 0 000000 0 1f 08 00000000 // debug ndmreset
00 0 000000 1 1f 08 00000000

/* test/tb_mcu_pwr.sv */
// Self-checking testbench for the power and reset control. Run it from the project root.
// Steps and expected values come from test/pwr_stim.mem with seven hex words per step.
`timescale 1ns/1ns
`default_nettype none

module tb_mcu_pwr
  import mcu_pwr_pkg::*;
();

  localparam int NUM_STEPS  = 19;
  localparam int WORDS      = 7;
  localparam int MAX_CYCLES = NUM_STEPS * 40 + 10;

  logic                        clk;
  logic                        arst_n;
  pwr_cmd_t                    pwr_cmd;
  logic                        core_sleep;
  logic                        debug_ndmreset_n;
  irq_src_t                    irq_src;
  dom_vec_t                    switch_ack_n;
  pwr_ctrl_t [NUM_DOMAINS-1:0] dom_ctrl;
  dom_vec_t                    dom_rst_n;
  dom_vec_t                    dom_on;
  dom_vec_t                    dom_busy;
  irq_vec_t                    intr;

  logic [31:0] stim_mem [NUM_STEPS*WORDS];
  logic [2:0]  ack_delay [NUM_DOMAINS];
  int          errors;
  int          checks;
  int          cycles;

  mcu_pwr_top i_mcu_pwr_top (
    .clk_i             (clk),
    .arst_n_i          (arst_n),
    .pwr_cmd_i         (pwr_cmd),
    .core_sleep_i      (core_sleep),
    .debug_ndmreset_ni (debug_ndmreset_n),
    .irq_src_i         (irq_src),
    .switch_ack_ni     (switch_ack_n),
    .dom_ctrl_o        (dom_ctrl),
    .dom_rst_no        (dom_rst_n),
    .dom_on_o          (dom_on),
    .dom_busy_o        (dom_busy),
    .intr_o            (intr)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // power switch model with an ack delay of 1 to 4 cycles
  initial begin
    void'($urandom(32'hd523));
    switch_ack_n = '0;
    for (int d = 0; d < NUM_DOMAINS; d++) begin
      ack_delay[d] = 3'd0;
    end
    forever begin
      @(posedge clk);
      for (int d = 0; d < NUM_DOMAINS; d++) begin
        if (switch_ack_n[d] != dom_ctrl[d].pwrgate_en_n) begin
          ack_delay[d] <= 3'd0;
        end else if (ack_delay[d] == 3'd0) begin
          ack_delay[d] <= 3'(1 + $urandom % 4);
        end else if (ack_delay[d] == 3'd1) begin
          switch_ack_n[d] <= ~switch_ack_n[d];
          ack_delay[d]    <= 3'd0;
        end else begin
          ack_delay[d] <= ack_delay[d] - 3'd1;
        end
      end
    end
  end

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %s at cycle %0d: got 0x%0h expected 0x%0h", name, cycles, got, exp);
    end
  endtask

  // controls follow the on flag and the retention bit follows exp_ret
  task automatic check_domains(input dom_vec_t exp_on, input dom_vec_t exp_ret,
                               input logic dbg);
    logic [4:0] exp_ctrl;
    check_value("dom_on_o", 32'(dom_on), 32'(exp_on));
    check_value("dom_rst_no", 32'(dom_rst_n), dbg ? 32'(exp_on) : 32'h0);
    for (int d = 0; d < NUM_DOMAINS; d++) begin
      exp_ctrl = {{4{exp_on[d]}}, ~exp_ret[d]};
      check_value($sformatf("dom_ctrl_o[%0d]", d), 32'(dom_ctrl[d]), 32'(exp_ctrl));
    end
  endtask

  initial begin
    int base;
    errors           = 0;
    checks           = 0;
    arst_n           = 1'b0;
    pwr_cmd          = '0;
    core_sleep       = 1'b0;
    debug_ndmreset_n = 1'b1;
    irq_src          = '0;
    $readmemh("test/pwr_stim.mem", stim_mem);
    repeat (5) @(posedge clk);
    arst_n <= 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    check_value("dom_busy_o", 32'(dom_busy), 32'h0);
    check_domains('1, '0, 1'b1);
    for (int s = 0; s < NUM_STEPS; s++) begin
      base = s * WORDS;
      @(posedge clk);
      pwr_cmd          <= pwr_cmd_t'(stim_mem[base][5:0]);
      core_sleep       <= stim_mem[base+1][0];
      irq_src          <= irq_src_t'(stim_mem[base+2][20:0]);
      debug_ndmreset_n <= stim_mem[base+3][0];
      @(posedge clk);
      pwr_cmd <= '0;
      // sources reach intr_o one clock later
      @(negedge clk);
      check_value("intr_o", intr, stim_mem[base+6]);
      // target and sequencer need two more clocks to react
      repeat (2) @(posedge clk);
      @(negedge clk);
      while (dom_busy != '0) @(negedge clk);
      check_domains(stim_mem[base+4][4:0], stim_mem[base+5][4:0], stim_mem[base+3][0]);
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
    $display("checks: %0d, errors: %0d", checks, errors);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire
